// ==== all.f ====
verilog/icache_pkg.sv
verilog/way_sram.sv
verilog/refill_ctrl.sv
verilog/icache_core.sv
verilog/icache_top.sv
tb/icache_asserts.sv
tb/icache_monitor.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f all.f -o icache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/icache_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== tb/icache_asserts.sv ====
module icache_asserts import icache_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input logic                       clk,
	input logic                       rst,
	input logic                       mem_req,
	input logic                       mem_ack,
	input logic [ADDR_W-OFFSET_W-1:0] mem_line_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;    // read by the testbench top

	a_req_held: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req)
		else begin
			fail_count++;
			$error("mem_req dropped before mem_ack was seen");
		end

	a_addr_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req && $past(mem_req) |-> $stable(mem_line_addr))
		else begin
			fail_count++;
			$error("mem_line_addr changed while mem_req was high");
		end

	// phase 4 must finish before the next request
	a_no_early_req: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !$past(mem_ack))
		else begin
			fail_count++;
			$error("mem_req rose while mem_ack was still high");
		end

endmodule

bind icache_top icache_asserts #(.ADDR_W(ADDR_W)) u_asserts (
	.clk          (clk),
	.rst          (rst),
	.mem_req      (mem_req),
	.mem_ack      (mem_ack),
	.mem_line_addr(mem_line_addr)
);

// ==== tb/icache_monitor.sv ====
module icache_monitor import icache_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int SET_W = 6,
	parameter int WAYS = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       fetch_valid,
	input  logic [ADDR_W-1:0]          fetch_addr,
	input  logic                       fetch_ready,
	input  logic                       flush,
	input  logic                       resp_valid,
	input  word_t                      resp_inst,
	input  logic                       mem_req,
	input  logic                       mem_ack,
	input  logic [ADDR_W-OFFSET_W-1:0] mem_line_addr,
	output int                         err_count,
	output int                         check_count,
	output int                         pending
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LA_W = ADDR_W - OFFSET_W;
	localparam int TAG_W = LA_W - SET_W;
	localparam int SETS = 1 << SET_W;

	// outstanding requests, oldest first
	logic [ADDR_W-1:0] q_addr [$];
	longint q_cyc [$];
	int q_ref [$];        // refill count seen at acceptance
	bit q_miss [$];

	logic [TAG_W-1:0] m_tag [SETS][WAYS];
	logic [WAYS-1:0] m_valid [SETS];
	logic [WAYS-1:0] m_victim [SETS];    // one-hot replacement pointer
	longint cycle;
	int refills;
	logic req_d;
	bit rst_seen;

	// content rule of the memory model
	function automatic word_t word_at(input logic [ADDR_W-1:0] a);
		return a[WORD_W-1:0] * 32'h9e37_79b9 + 32'd1;
	endfunction

	function automatic bit cached(input logic [LA_W-1:0] la);
		bit found;
		found = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[la[SET_W-1:0]][w] && m_tag[la[SET_W-1:0]][w] == la[LA_W-1:SET_W]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic install(input logic [LA_W-1:0] la);
		logic [SET_W-1:0] s;
		s = la[SET_W-1:0];
		for (int w = 0; w < WAYS; w++) begin
			if (m_victim[s][w]) m_tag[s][w] = la[LA_W-1:SET_W];
		end
		m_valid[s] = m_valid[s] | m_victim[s];
		m_victim[s] = {m_victim[s][WAYS-2:0], m_victim[s][WAYS-1]};
	endtask

	task automatic drop_all();
		q_addr.delete();
		q_cyc.delete();
		q_ref.delete();
		q_miss.delete();
	endtask

	task automatic take_response();
		logic [ADDR_W-1:0] a;
		longint acc;
		int ref_at;
		bit was_miss;
		check_count++;
		if (q_addr.size() == 0) begin
			err_count++;
			$display("%0t response appeared with no outstanding request", $time);
		end else begin
			a = q_addr.pop_front();
			acc = q_cyc.pop_front();
			ref_at = q_ref.pop_front();
			was_miss = q_miss.pop_front();
			if (resp_inst !== word_at(a)) begin
				err_count++;
				$display("[ERROR] %0t resp_inst expected %h actual %h", $time, word_at(a), resp_inst);
			end
			if (!was_miss && !cached(a[ADDR_W-1:OFFSET_W])) begin
				err_count++;
				$display("%0t request %h answered without the refill its miss needs", $time, a);
			end
			// a hit with no refill in between takes exactly two cycles
			if (!was_miss && ref_at == refills && cycle - acc != 3) begin
				err_count++;
				$display("[ERROR] %0t resp_valid latency expected 2 actual %0d", $time, cycle - acc - 1);
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			if (rst_seen) begin
				check_count++;
				if (mem_req !== 1'b0) begin
					err_count++;
					$display("[ERROR] %0t mem_req expected 0 actual %b", $time, mem_req);
				end
				if (resp_valid !== 1'b0) begin
					err_count++;
					$display("[ERROR] %0t resp_valid expected 0 actual %b", $time, resp_valid);
				end
				if (fetch_ready !== 1'b1) begin
					err_count++;
					$display("[ERROR] %0t fetch_ready expected 1 actual %b", $time, fetch_ready);
				end
			end
			rst_seen = 1'b1;
			for (int s = 0; s < SETS; s++) begin
				m_valid[s] = '0;
				m_victim[s] = {{(WAYS-1){1'b0}}, 1'b1};
			end
			drop_all();
			cycle = 0;
			refills = 0;
			req_d = 1'b0;
		end else begin
			cycle++;
			if (resp_valid) take_response();
			if (mem_req && !req_d) begin
				refills++;
				check_count++;
				if (cached(mem_line_addr)) begin
					err_count++;
					$display("%0t memory request for line %h that is already cached", $time,
						mem_line_addr);
				end
				if (q_addr.size() != 0) begin
					if (mem_line_addr !== q_addr[0][ADDR_W-1:OFFSET_W]) begin
						err_count++;
						$display("[ERROR] %0t mem_line_addr expected %h actual %h", $time,
							q_addr[0][ADDR_W-1:OFFSET_W], mem_line_addr);
					end
					q_miss[0] = 1'b1;
				end
			end
			if (mem_req && mem_ack) install(mem_line_addr);    // line taken at this edge
			if (flush) drop_all();
			if (fetch_valid && fetch_ready) begin
				q_addr.push_back(fetch_addr);
				q_cyc.push_back(cycle);
				q_ref.push_back(refills);
				q_miss.push_back(1'b0);
			end
			req_d = mem_req;
		end
		pending = q_addr.size();
	end

	initial begin
		err_count = 0;
		check_count = 0;
		pending = 0;
		rst_seen = 1'b0;
	end

endmodule

// ==== tb/icache_tb.sv ====
module icache_tb import icache_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_W = 32;
	localparam int SET_W = 6;
	localparam int WAYS = 4;
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;
	localparam int NUM_REQ = 2000;
	localparam int WAIT_MAX = 200;      // cycles for one accept or drain
	localparam int IDLE_MAX = 20000;    // cycles without any memory request

	logic clk;
	logic rst;
	logic fetch_valid;
	logic [ADDR_W-1:0] fetch_addr;
	logic fetch_ready;
	logic flush;
	logic resp_valid;
	word_t resp_inst;
	logic mem_req;
	logic [ADDR_W-OFFSET_W-1:0] mem_line_addr;
	logic mem_ack;
	line_t mem_line;

	int seed;
	int err_count;
	int check_count;
	int pending;
	bit stim_done;

	icache_top #(.ADDR_W(ADDR_W), .SET_W(SET_W), .WAYS(WAYS)) u_dut (
		.clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready), .flush(flush), .resp_valid(resp_valid),
		.resp_inst(resp_inst), .mem_req(mem_req), .mem_line_addr(mem_line_addr),
		.mem_ack(mem_ack), .mem_line(mem_line)
	);

	icache_monitor #(.ADDR_W(ADDR_W), .SET_W(SET_W), .WAYS(WAYS)) u_mon (
		.clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready), .flush(flush), .resp_valid(resp_valid),
		.resp_inst(resp_inst), .mem_req(mem_req), .mem_ack(mem_ack),
		.mem_line_addr(mem_line_addr), .err_count(err_count), .check_count(check_count),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory line by the content rule, word 0 low
	function automatic line_t line_at(input logic [ADDR_W-OFFSET_W-1:0] la);
		line_t l;
		logic [ADDR_W-1:0] a;
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			a = {la, 4'h0} + ADDR_W'(4 * i);
			l[i*WORD_W +: WORD_W] = a[WORD_W-1:0] * 32'h9e37_79b9 + 32'd1;
		end
		return l;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int word);
		return {TAG_W'(tag), SET_W'(set), 2'(word), 2'b00};
	endfunction

	function automatic int pick(input int range);
		return int'($unsigned($random(seed)) % range);
	endfunction

	task automatic finish_run(input bit timed_out);
		int asrt;
		asrt = u_dut.u_asserts.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", check_count, err_count, asrt);
		if (!timed_out && err_count == 0 && asrt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s", what);
		finish_run(1'b1);
	endtask

	task automatic fetch_one(input logic [ADDR_W-1:0] addr, input bit with_flush);
		int n;
		if (with_flush) begin
			flush = 1'b1;
			@(posedge clk);
			#1 flush = 1'b0;
		end
		fetch_valid = 1'b1;
		fetch_addr = addr;
		n = 0;
		@(negedge clk);    // fetch_ready is settled mid-cycle
		while (!fetch_ready && n <= WAIT_MAX) begin
			n++;
			@(negedge clk);
		end
		if (n > WAIT_MAX) begin
			timeout_fail("fetch request was never accepted");
		end else begin
			@(posedge clk);    // taken at this edge
			#1 fetch_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (pending != 0 && n <= WAIT_MAX) begin
			@(posedge clk);
			#1 n++;
		end
		if (n > WAIT_MAX) timeout_fail("outstanding requests never answered");
	endtask

	task automatic wait_mem_req();
		int n;
		n = 0;
		while (!mem_req && n <= WAIT_MAX) begin
			@(posedge clk);
			#1 n++;
		end
		if (n > WAIT_MAX) timeout_fail("expected memory request never came");
	endtask

	// four-phase responder with a random ack delay
	initial begin : responder
		int n;
		int d;
		mem_ack = 1'b0;
		mem_line = '0;
		while (!stim_done) begin
			n = 0;
			while (mem_req !== 1'b1 && !stim_done && n < IDLE_MAX) begin
				@(posedge clk);
				#1 n++;
			end
			if (n >= IDLE_MAX) begin
				timeout_fail("no memory request for too long");
			end else if (mem_req) begin
				d = 1 + pick(6);
				repeat (d) @(posedge clk);
				#1 mem_ack = 1'b1;
				mem_line = line_at(mem_line_addr);
				n = 0;
				while (mem_req && n <= WAIT_MAX) begin
					@(posedge clk);
					#1 n++;
				end
				if (mem_req) begin
					timeout_fail("mem_req stayed high after mem_ack");
				end else begin
					// ack may outlive the request by a few cycles
					repeat (pick(5)) begin
						@(posedge clk);
						#1;
					end
					mem_ack = 1'b0;
				end
			end
		end
	end

	initial begin : stimulus
		int sets [3];
		sets = '{5, 9, 40};
		seed = 32'hb05e_f0a3;
		stim_done = 1'b0;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;

		// five lines into set 3, the fifth evicts the first
		for (int t = 1; t <= 5; t++) begin
			fetch_one(make_addr(t, 3, t % 4), 1'b0);
			drain();
		end
		fetch_one(make_addr(1, 3, 2), 1'b0);    // misses again, evicts tag 2
		for (int t = 3; t <= 5; t++) fetch_one(make_addr(t, 3, 0), 1'b0);
		drain();

		// flush during a refill, the line still lands
		fetch_one(make_addr(7, 12, 1), 1'b0);
		wait_mem_req();
		flush = 1'b1;
		@(posedge clk);
		#1 flush = 1'b0;
		fetch_one(make_addr(7, 12, 3), 1'b0);
		drain();

		for (int i = 0; i < NUM_REQ; i++) begin
			fetch_one(make_addr(8 + pick(6), sets[pick(3)], pick(4)), pick(60) == 0);
			if (pick(4) == 0) begin
				@(posedge clk);
				#1;
			end
		end
		drain();
		stim_done = 1'b1;
		repeat (4) @(posedge clk);
		finish_run(1'b0);
	end

endmodule

// ==== verilog/icache_core.sv ====
module icache_core import icache_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int SET_W = 6,
	parameter int WAYS = 4,
	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       fetch_valid,
	input  logic [ADDR_W-1:0]          fetch_addr,
	output logic                       fetch_ready,
	input  logic                       flush,
	output logic                       resp_valid,
	output word_t                      resp_inst,
	output logic [WAYS-1:0]            sram_en,
	output logic [WAYS-1:0]            sram_we,
	output logic [SET_W-1:0]           sram_addr,
	output logic [TAG_W-1:0]           tag_wdata,
	input  logic [TAG_W-1:0]           tag_rdata [WAYS],
	output line_t                      data_wdata,
	input  line_t                      data_rdata [WAYS],
	output logic                       refill_start,
	output logic [ADDR_W-OFFSET_W-1:0] refill_line_addr,
	input  logic                       refill_done,
	input  line_t                      refill_line
);

	localparam int SETS = 1 << SET_W;
	localparam int WSEL_W = $clog2(WORDS_PER_LINE);

	// lookup stage, the set read is issued from here
	logic s1_valid;
	logic [ADDR_W-1:0] s1_addr;
	logic [SET_W-1:0] s1_set;

	// compare stage, sram data arrives here
	logic s2_valid;
	logic [ADDR_W-1:0] s2_addr;
	logic [SET_W-1:0] s2_set;
	logic [TAG_W-1:0] s2_tag;
	logic [WSEL_W-1:0] s2_word;

	logic miss_wait;     // refill in progress for the compare stage
	logic cmp_valid;
	logic cmp_hit;
	logic cmp_miss;
	logic s1_move;
	logic wr;
	logic [WAYS-1:0] hit_way;
	line_t hit_line;
	word_t hit_word;
	word_t fill_word;

	logic [WAYS-1:0] vbits [SETS];
	logic [WAYS-1:0] victim [SETS];    // one-hot, rotates per refill of its set

	assign s1_set = s1_addr[OFFSET_W +: SET_W];
	assign s2_set = s2_addr[OFFSET_W +: SET_W];
	assign s2_tag = s2_addr[ADDR_W-1 -: TAG_W];
	assign s2_word = s2_addr[OFFSET_W-1 -: WSEL_W];

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit_way[w] = vbits[s2_set][w] && (tag_rdata[w] == s2_tag);
			if (hit_way[w]) begin
				hit_line = hit_line | data_rdata[w];
			end
		end
	end

	assign hit_word = hit_line[s2_word*WORD_W +: WORD_W];
	assign fill_word = refill_line[s2_word*WORD_W +: WORD_W];

	// rdata is only fresh in the first cycle of the compare stage
	assign cmp_valid = s2_valid && !miss_wait;
	assign cmp_hit = cmp_valid && (|hit_way);
	assign cmp_miss = cmp_valid && !(|hit_way);
	assign refill_start = cmp_miss && !flush;
	assign refill_line_addr = s2_addr[ADDR_W-1:OFFSET_W];
	assign wr = refill_done && miss_wait;

	// lookup moves on only in a cycle where its own read was done
	assign s1_move = s1_valid && !cmp_miss && !miss_wait;
	assign fetch_ready = !(flush || cmp_miss || miss_wait);

	// refill write takes the port, otherwise read the lookup set
	assign sram_en = wr ? victim[s2_set] : {WAYS{s1_valid}};
	assign sram_we = wr ? victim[s2_set] : '0;
	assign sram_addr = wr ? s2_set : s1_set;
	assign tag_wdata = s2_tag;
	assign data_wdata = refill_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			miss_wait <= 1'b0;
		end else begin
			if (flush) begin
				s1_valid <= 1'b0;
			end else if (fetch_valid && fetch_ready) begin
				s1_valid <= 1'b1;
			end else if (s1_move) begin
				s1_valid <= 1'b0;
			end

			// a flushed miss keeps s2_addr so the fill still lands
			if (flush) begin
				s2_valid <= 1'b0;
			end else if (s1_move) begin
				s2_valid <= 1'b1;
			end else if (cmp_hit || wr) begin
				s2_valid <= 1'b0;
			end

			if (refill_start) begin
				miss_wait <= 1'b1;
			end else if (refill_done) begin
				miss_wait <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid && fetch_ready) begin
			s1_addr <= fetch_addr;
		end
		if (s1_move) begin
			s2_addr <= s1_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				vbits[s] <= '0;
				victim[s] <= {{(WAYS-1){1'b0}}, 1'b1};   // way 0 first
			end
		end else if (wr) begin
			vbits[s2_set] <= vbits[s2_set] | victim[s2_set];
			victim[s2_set] <= {victim[s2_set][WAYS-2:0], victim[s2_set][WAYS-1]};
		end
	end

	// one response per hit or per unflushed refill
	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= !flush && (cmp_hit || (wr && s2_valid));
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			resp_inst <= fill_word;   // missing word straight from the new line
		end else if (cmp_hit) begin
			resp_inst <= hit_word;
		end
	end

endmodule

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

	// fetch word and line geometry
	localparam int WORD_W = 32;          // one instruction
	localparam int LINE_W = 128;         // one cache line
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_W = 4;         // byte offset inside a line

	typedef logic [WORD_W-1:0] word_t;

	// word 0 sits in the low bits, word 3 in the top bits
	typedef logic [LINE_W-1:0] line_t;

endpackage

// ==== verilog/icache_top.sv ====
module icache_top import icache_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int SET_W = 6,
	parameter int WAYS = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       fetch_valid,
	input  logic [ADDR_W-1:0]          fetch_addr,
	output logic                       fetch_ready,
	input  logic                       flush,
	output logic                       resp_valid,
	output word_t                      resp_inst,
	output logic                       mem_req,
	output logic [ADDR_W-OFFSET_W-1:0] mem_line_addr,
	input  logic                       mem_ack,
	input  line_t                      mem_line
);

	localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;
	localparam int SETS = 1 << SET_W;

	typedef logic [TAG_W-1:0] tag_t;

	logic [WAYS-1:0] sram_en;
	logic [WAYS-1:0] sram_we;
	logic [SET_W-1:0] sram_addr;
	tag_t tag_wdata;
	tag_t tag_rdata [WAYS];
	line_t data_wdata;
	line_t data_rdata [WAYS];

	logic refill_start;
	logic refill_done;
	logic [ADDR_W-OFFSET_W-1:0] refill_line_addr;
	line_t refill_line;

	icache_core #(
		.ADDR_W(ADDR_W),
		.SET_W (SET_W),
		.WAYS  (WAYS)
	) u_core (
		.clk             (clk),
		.rst             (rst),
		.fetch_valid     (fetch_valid),
		.fetch_addr      (fetch_addr),
		.fetch_ready     (fetch_ready),
		.flush           (flush),
		.resp_valid      (resp_valid),
		.resp_inst       (resp_inst),
		.sram_en         (sram_en),
		.sram_we         (sram_we),
		.sram_addr       (sram_addr),
		.tag_wdata       (tag_wdata),
		.tag_rdata       (tag_rdata),
		.data_wdata      (data_wdata),
		.data_rdata      (data_rdata),
		.refill_start    (refill_start),
		.refill_line_addr(refill_line_addr),
		.refill_done     (refill_done),
		.refill_line     (refill_line)
	);

	// tag and data arrays share enable, write and index per way
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		way_sram #(.entry_t(tag_t), .DEPTH(SETS)) u_tag (
			.clk(clk), .en(sram_en[w]), .we(sram_we[w]), .addr(sram_addr),
			.wdata(tag_wdata), .rdata(tag_rdata[w])
		);
		way_sram #(.entry_t(line_t), .DEPTH(SETS)) u_data (
			.clk(clk), .en(sram_en[w]), .we(sram_we[w]), .addr(sram_addr),
			.wdata(data_wdata), .rdata(data_rdata[w])
		);
	end

	refill_ctrl #(.ADDR_W(ADDR_W)) u_refill (
		.clk             (clk),
		.rst             (rst),
		.refill_start    (refill_start),
		.refill_line_addr(refill_line_addr),
		.refill_done     (refill_done),
		.refill_line     (refill_line),
		.mem_req         (mem_req),
		.mem_line_addr   (mem_line_addr),
		.mem_ack         (mem_ack),
		.mem_line        (mem_line)
	);

endmodule

// ==== verilog/refill_ctrl.sv ====
module refill_ctrl import icache_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       refill_start,
	input  logic [ADDR_W-OFFSET_W-1:0] refill_line_addr,
	output logic                       refill_done,
	output line_t                      refill_line,
	output logic                       mem_req,
	output logic [ADDR_W-OFFSET_W-1:0] mem_line_addr,
	input  logic                       mem_ack,
	input  line_t                      mem_line
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_HI,
		WAIT_LO
	} state_t;

	state_t state;
	logic start_pend;    // start seen while the old ack was still high
	logic take_start;
	logic take_line;

	assign take_start = refill_start && (state == IDLE || state == WAIT_LO);
	assign take_line = (state == WAIT_HI) && mem_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			mem_req <= 1'b0;
			refill_done <= 1'b0;
			start_pend <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				IDLE: begin
					if (refill_start) begin
						state <= WAIT_HI;
						mem_req <= 1'b1;
					end
				end
				WAIT_HI: begin
					if (mem_ack) begin
						state <= WAIT_LO;
						mem_req <= 1'b0;       // phase 3
						refill_done <= 1'b1;
					end
				end
				WAIT_LO: begin
					if (!mem_ack) begin
						// phase 4 done, a queued start goes out right away
						state <= (start_pend || refill_start) ? WAIT_HI : IDLE;
						mem_req <= start_pend || refill_start;
						start_pend <= 1'b0;
					end else if (refill_start) begin
						start_pend <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
					mem_req <= 1'b0;
				end
			endcase
		end
	end

	// address and line registers
	always_ff @(posedge clk) begin
		if (take_start) begin
			mem_line_addr <= refill_line_addr;  // held for the whole handshake
		end
		if (take_line) begin
			refill_line <= mem_line;
		end
	end

endmodule

// ==== verilog/way_sram.sv ====
module way_sram #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 64
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  entry_t                   wdata,
	output entry_t                   rdata
);

	entry_t mem [DEPTH];

	// single port, so a write and a read never share a cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];     // registered read
			end
		end
	end

endmodule
